// ==== sources.f ====
+incdir+logic
logic/dcache_pkg.sv
logic/way_ctrl_if.sv
logic/cache_arrays.sv
logic/miss_ctrl.sv
logic/dcache.sv
tests/dcache_checker.sv
tests/dcache_tb.sv

// ==== Makefile ====
# Verilator flow for the data cache testbench
VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o V$(TOP)

sim: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "result: FAIL"; exit 1; fi
	@if ! grep -q "Simulation passed" $(LOG); then echo "result: no verdict"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/dcache_tb.sv ====
//----------------------------------------------------------------------
// Testbench for the two-way data cache. A word memory with random wait
// states serves the bus. A shadow memory and a tag model give the
// expected load and first-cycle hit of every access. Directed cases
// run first, then a seeded random mix over four sets and four tags.
//----------------------------------------------------------------------
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_tb;

    localparam int N_DIRECTED = 12;
    localparam int N_RAND     = 200;
    localparam int N_OPS      = N_DIRECTED + N_RAND;

    logic CLK = 1'b0;
    logic nRST, dmem_ren, dmem_wen, mem_wait, dhit, mem_ren, mem_wen;
    dcache_pkg::word_t dmem_addr, dmem_store, mem_load, dmem_load, mem_addr, mem_store;

    dcache_pkg::word_t    mem         [1024];
    dcache_pkg::word_t    shadow      [1024];  // what the processor should read back
    logic [`DC_TAG_W-1:0] model_tag   [`DC_SETS][2];
    logic                 model_valid [`DC_SETS][2];
    logic                 model_lru   [`DC_SETS];  // way the next miss replaces
    logic [31:0]          wait_seed, stim_seed;
    logic                 exp_hit;
    dcache_pkg::word_t    exp_load;
    int                   req_id = 0;
    int                   checked_id = 0;
    int                   ops_done = 0;

    always #10 CLK = ~CLK;

    dcache dcache_inst (
        .CLK(CLK), .nRST(nRST), .dmem_ren(dmem_ren), .dmem_wen(dmem_wen),
        .mem_wait(mem_wait), .dmem_addr(dmem_addr), .dmem_store(dmem_store),
        .mem_load(mem_load), .dmem_load(dmem_load), .mem_addr(mem_addr),
        .mem_store(mem_store), .dhit(dhit), .mem_ren(mem_ren), .mem_wen(mem_wen)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic dcache_pkg::word_t make_addr(input int tag, input int idx, input int off);
        dcache_pkg::dcache_addr_u a;
        a.fields.tag     = `DC_TAG_W'(tag);
        a.fields.idx     = `DC_IDX_W'(idx);
        a.fields.blkoff  = 1'(off);
        a.fields.byteoff = 2'b00;
        return a.word;
    endfunction

    function automatic dcache_pkg::word_t expected_load(input dcache_pkg::word_t addr);
        return shadow[addr[11:2]];
    endfunction

    function automatic logic expected_hit(input dcache_pkg::word_t addr);
        dcache_pkg::dcache_addr_u a;
        a.word = addr;
        for (int w = 0; w < 2; w++) begin
            if (model_valid[a.fields.idx][w] && model_tag[a.fields.idx][w] == a.fields.tag)
                return 1'b1;
        end
        return 1'b0;
    endfunction

    // a finished access leaves its tag in the hit way or the LRU victim
    task automatic update_model(input logic wr, input dcache_pkg::word_t addr,
                                input dcache_pkg::word_t data);
        dcache_pkg::dcache_addr_u a;
        int way;
        a.word = addr;
        way    = model_lru[a.fields.idx] ? 1 : 0;
        for (int w = 0; w < 2; w++) begin
            if (model_valid[a.fields.idx][w] && model_tag[a.fields.idx][w] == a.fields.tag)
                way = w;
        end
        model_tag[a.fields.idx][way]   = a.fields.tag;
        model_valid[a.fields.idx][way] = 1'b1;
        model_lru[a.fields.idx]        = (way == 0);
        if (wr) shadow[addr[11:2]] = data;
    endtask

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic access(input logic wr, input dcache_pkg::word_t addr,
                          input dcache_pkg::word_t data);
        exp_hit  = expected_hit(addr);
        exp_load = expected_load(addr);
        @(posedge CLK);
        #1;
        dmem_ren   = !wr;
        dmem_wen   = wr;
        dmem_addr  = addr;
        dmem_store = data;
        req_id++;
        @(negedge CLK);
        while (!dhit) @(negedge CLK);
        update_model(wr, addr, data);
        ops_done++;
        @(posedge CLK);
        #1;
        dmem_ren = 1'b0;
        dmem_wen = 1'b0;
    endtask

    // writes are captured in the cycle they complete and wait and load change 1 ns after the edge
    initial begin
        mem_wait  = 1'b0;
        mem_load  = '0;
        wait_seed = 32'hc60a_5623;
        for (int i = 0; i < 1024; i++) mem[i] = 32'(i) * 32'h9e37_79b1;
        forever begin
            @(negedge CLK);
            if (mem_wen && !mem_wait) mem[mem_addr[11:2]] = mem_store;
            @(posedge CLK);
            #1;
            wait_seed = lcg_next(wait_seed);
            mem_wait  = wait_seed[31];
            mem_load  = mem_ren ? mem[mem_addr[11:2]] : 32'hdead_beef;  // no data without a read
        end
    end

    always @(negedge CLK) begin
        if ((dmem_ren || dmem_wen) && req_id != checked_id) begin
            assert (dhit === exp_hit) else begin
                $display("Error: dhit = %h, expected %h, dmem_addr = %h", dhit, exp_hit, dmem_addr);
                abort_run();
            end
            checked_id = req_id;
        end
        if (dmem_ren && dhit) begin
            assert (dmem_load === exp_load) else begin
                $display("Error: dmem_load = %h, expected %h", dmem_load, exp_load);
                abort_run();
            end
        end
        assert (dcache_inst.bus_chk.violations == 0) else begin
            $display("The bus checker reported a protocol violation");
            abort_run();
        end
    end

    initial begin
        repeat (16 + N_OPS * 40) @(posedge CLK);
        $display("Watchdog expired with %0d of %0d accesses done", ops_done, N_OPS);
        abort_run();
    end

    initial begin
        nRST = 1'b0;
        {dmem_ren, dmem_wen, dmem_addr, dmem_store} = '0;
        stim_seed = lcg_next(32'hc60a_5623);
        for (int i = 0; i < 1024; i++) shadow[i] = 32'(i) * 32'h9e37_79b1;
        for (int s = 0; s < `DC_SETS; s++) begin
            model_lru[s] = 1'b0;
            model_valid[s] = '{2{1'b0}};
            model_tag[s] = '{default: '0};
        end
        repeat (16) @(posedge CLK);
        #1 nRST = 1'b1;
        @(negedge CLK);
        assert (!mem_ren && !mem_wen) else begin
            $display("Error: mem_ren = %h, mem_wen = %h, expected 0", mem_ren, mem_wen);
            abort_run();
        end
        access(1'b0, make_addr(1, 0, 0), '0);               // cold miss
        access(1'b1, make_addr(1, 0, 1), 32'h1234_5678);    // write hit makes set 0 dirty
        access(1'b0, make_addr(1, 0, 1), '0);
        access(1'b0, make_addr(2, 0, 0), '0);
        access(1'b0, make_addr(3, 0, 1), '0);               // evicts the dirty line
        access(1'b0, make_addr(1, 0, 1), '0);               // comes back from memory
        access(1'b0, make_addr(4, 1, 0), '0);
        access(1'b0, make_addr(5, 1, 0), '0);
        access(1'b0, make_addr(4, 1, 1), '0);
        access(1'b0, make_addr(6, 1, 1), '0);               // tag 5 is the LRU victim
        access(1'b0, make_addr(4, 1, 0), '0);
        access(1'b0, make_addr(5, 1, 1), '0);
        repeat (N_RAND) begin
            stim_seed = lcg_next(stim_seed);
            access(stim_seed[31],
                   make_addr(int'(stim_seed[30:29]), int'(stim_seed[28:27]), int'(stim_seed[26])),
                   lcg_next(stim_seed));
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== tests/dcache_checker.sv ====
//----------------------------------------------------------------------
// Bus protocol assertions for the data cache, bound into the top level.
// Checks that read and write never overlap, that a waiting request
// holds still, and that hits only come from an idle controller.
//----------------------------------------------------------------------
`timescale 1ns/1ps

module dcache_checker (
    input logic                    CLK,
    input logic                    nRST,
    input logic                    mem_ren,
    input logic                    mem_wen,
    input logic                    mem_wait,
    input logic                    dhit,
    input dcache_pkg::word_t       mem_addr,
    input dcache_pkg::word_t       mem_store,
    input dcache_pkg::miss_state_e state
);

    int unsigned violations = 0;  // read by the testbench

    bus_exclusive: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_ren && mem_wen))
        else begin
            $error("memory read and write requested in the same cycle");
            violations++;
        end

    request_held: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_wait && (mem_ren || mem_wen)) |=> ($stable(mem_addr) && $stable(mem_store)))
        else begin
            $error("memory request changed while the bus was waiting");
            violations++;
        end

    hit_when_idle: assert property (@(posedge CLK) disable iff (!nRST)
        dhit |-> (state == dcache_pkg::IDLE))
        else begin
            $error("hit reported while the miss controller was busy");
            violations++;
        end

endmodule

bind dcache dcache_checker bus_chk (
    .CLK(CLK), .nRST(nRST), .mem_ren(mem_ren), .mem_wen(mem_wen), .mem_wait(mem_wait),
    .dhit(dhit), .mem_addr(mem_addr), .mem_store(mem_store), .state(ctrl_inst.state)
);

// ==== logic/dcache.sv ====
//----------------------------------------------------------------------
// Top level of the two-way write-back data cache. The processor port
// goes to the arrays, the word-wide memory bus to the miss controller,
// and the two talk over the way control interface.
//----------------------------------------------------------------------
`timescale 1ns/1ps

module dcache (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              dmem_ren,
    input  logic              dmem_wen,
    input  logic              mem_wait,
    input  dcache_pkg::word_t dmem_addr,
    input  dcache_pkg::word_t dmem_store,
    input  dcache_pkg::word_t mem_load,
    output dcache_pkg::word_t dmem_load,
    output dcache_pkg::word_t mem_addr,
    output dcache_pkg::word_t mem_store,
    output logic              dhit,
    output logic              mem_ren,
    output logic              mem_wen
);

    dcache_pkg::word_t victim_data;  // word of the victim block under write-back

    way_ctrl_if wc ();

    cache_arrays arrays_inst (
        .CLK         (CLK),
        .nRST        (nRST),
        .dmem_ren    (dmem_ren),
        .dmem_wen    (dmem_wen),
        .dmem_addr   (dmem_addr),
        .dmem_store  (dmem_store),
        .mem_load    (mem_load),
        .dmem_load   (dmem_load),
        .victim_data (victim_data),
        .dhit        (dhit),
        .ctl         (wc.arrays)
    );

    miss_ctrl ctrl_inst (
        .CLK         (CLK),
        .nRST        (nRST),
        .dmem_addr   (dmem_addr),
        .victim_data (victim_data),
        .mem_wait    (mem_wait),
        .mem_ren     (mem_ren),
        .mem_wen     (mem_wen),
        .mem_addr    (mem_addr),
        .mem_store   (mem_store),
        .ctl         (wc.ctrl)
    );

endmodule

// ==== logic/miss_ctrl.sv ====
//----------------------------------------------------------------------
// Miss sequencer. On a miss it writes back the victim block when it is
// dirty, then reads the requested block, one word per bus transfer.
// Each state holds its request until mem_wait drops.
//----------------------------------------------------------------------
`timescale 1ns/1ps

module miss_ctrl (
    input  logic              CLK,
    input  logic              nRST,
    input  dcache_pkg::word_t dmem_addr,
    input  dcache_pkg::word_t victim_data,
    input  logic              mem_wait,
    output logic              mem_ren,
    output logic              mem_wen,
    output dcache_pkg::word_t mem_addr,
    output dcache_pkg::word_t mem_store,
    way_ctrl_if.ctrl          ctl
);

    dcache_pkg::miss_state_e  state;
    dcache_pkg::miss_state_e  next_state;
    dcache_pkg::dcache_addr_u req;
    dcache_pkg::dcache_addr_u bus_addr;

    logic writing_back;
    logic second_word;

    assign req.word = dmem_addr;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state <= dcache_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            dcache_pkg::IDLE: begin
                if (ctl.miss) begin
                    next_state = ctl.victim_dirty ? dcache_pkg::WB0 : dcache_pkg::FILL0;
                end
            end
            dcache_pkg::WB0: begin
                if (!mem_wait) next_state = dcache_pkg::WB1;
            end
            dcache_pkg::WB1: begin
                if (!mem_wait) next_state = dcache_pkg::FILL0;
            end
            dcache_pkg::FILL0: begin
                if (!mem_wait) next_state = dcache_pkg::FILL1;
            end
            dcache_pkg::FILL1: begin
                if (!mem_wait) next_state = dcache_pkg::IDLE;
            end
            default: begin
                next_state = dcache_pkg::IDLE;
            end
        endcase
    end

    assign writing_back = (state == dcache_pkg::WB0) || (state == dcache_pkg::WB1);
    assign second_word  = (state == dcache_pkg::WB1) || (state == dcache_pkg::FILL1);

    assign mem_wen = writing_back;
    assign mem_ren = (state == dcache_pkg::FILL0) || (state == dcache_pkg::FILL1);

    // write-back goes to where the victim came from, fill to the request
    always_comb begin
        bus_addr.fields.tag     = writing_back ? ctl.victim_tag : req.fields.tag;
        bus_addr.fields.idx     = req.fields.idx;
        bus_addr.fields.blkoff  = second_word;
        bus_addr.fields.byteoff = 2'b00;
    end

    assign mem_addr  = bus_addr.word;
    assign mem_store = victim_data;

    assign ctl.wb_word   = second_word;
    assign ctl.fill_word = mem_ren & ~mem_wait;
    assign ctl.fill_last = (state == dcache_pkg::FILL1);
    assign ctl.wb_done   = (state == dcache_pkg::WB1) & ~mem_wait;

endmodule

// ==== logic/cache_arrays.sv ====
//----------------------------------------------------------------------
// Storage and hit logic of the two-way cache. Holds tag, valid, dirty
// and data for each way plus one LRU bit per set, answers hits in the
// same cycle and takes fill and write-back steps from the controller.
//----------------------------------------------------------------------
`timescale 1ns/1ps
`include "dcache_defs.svh"

module cache_arrays (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              dmem_ren,
    input  logic              dmem_wen,
    input  dcache_pkg::word_t dmem_addr,
    input  dcache_pkg::word_t dmem_store,
    input  dcache_pkg::word_t mem_load,
    output dcache_pkg::word_t dmem_load,
    output dcache_pkg::word_t victim_data,
    output logic              dhit,
    way_ctrl_if.arrays        ctl
);

    dcache_pkg::dcache_addr_u req;

    logic [`DC_TAG_W-1:0] tag_q   [2][`DC_SETS];
    logic [`DC_SETS-1:0]  valid_q [2];
    logic [`DC_SETS-1:0]  dirty_q [2];
    logic [`DC_SETS-1:0]  lru_q;  // way the next miss in the set replaces
    dcache_pkg::word_t    data_q  [2][`DC_SETS][`DC_BLK_WORDS];

    logic [1:0] way_hit;
    logic       req_active;
    logic       hit_way;
    logic       victim;

    assign req.word   = dmem_addr;
    assign req_active = dmem_ren | dmem_wen;
    assign victim     = lru_q[req.fields.idx];

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = valid_q[w][req.fields.idx]
                         && (tag_q[w][req.fields.idx] == req.fields.tag);
        end
    end

    // a tag lives in one way only, so way 1 hitting is the whole choice
    assign hit_way   = way_hit[1];
    assign dhit      = req_active & (|way_hit);
    assign dmem_load = data_q[hit_way][req.fields.idx][req.fields.blkoff];

    assign ctl.miss         = req_active & ~(|way_hit);
    assign ctl.victim_dirty = dirty_q[victim][req.fields.idx];
    assign ctl.victim_tag   = tag_q[victim][req.fields.idx];
    assign victim_data      = data_q[victim][req.fields.idx][ctl.wb_word];

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_q <= '{default: '0};
            dirty_q <= '{default: '0};
            lru_q   <= '0;
        end else begin
            if (dhit) begin
                lru_q[req.fields.idx] <= ~hit_way;  // the other way ages
                if (dmem_wen) begin
                    dirty_q[hit_way][req.fields.idx] <= 1'b1;
                end
            end
            if (ctl.fill_word) begin
                // invalid while half filled, valid once the second word lands
                valid_q[victim][req.fields.idx] <= ctl.fill_last;
                if (ctl.fill_last) begin
                    dirty_q[victim][req.fields.idx] <= 1'b0;
                end
            end
            if (ctl.wb_done) begin
                dirty_q[victim][req.fields.idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (dhit && dmem_wen) begin
            data_q[hit_way][req.fields.idx][req.fields.blkoff] <= dmem_store;
        end
        if (ctl.fill_word) begin
            data_q[victim][req.fields.idx][ctl.fill_last] <= mem_load;
            if (ctl.fill_last) begin
                tag_q[victim][req.fields.idx] <= req.fields.tag;
            end
        end
    end

endmodule

// ==== logic/way_ctrl_if.sv ====
//----------------------------------------------------------------------
// Handshake between the miss controller and the cache arrays. The
// arrays report the miss and the victim line, the controller steps the
// arrays through write-back and fill with single-cycle pulses.
//----------------------------------------------------------------------
`timescale 1ns/1ps
`include "dcache_defs.svh"

interface way_ctrl_if;

    logic                 miss;          // request present and no way hits
    logic                 victim_dirty;
    logic [`DC_TAG_W-1:0] victim_tag;

    logic fill_word;  // mem_load is accepted into the victim this cycle
    logic fill_last;  // accepted fill word is the second of the block
    logic wb_done;
    logic wb_word;    // selects the victim word driven to the bus

    modport arrays (
        output miss,
        output victim_dirty,
        output victim_tag,
        input  fill_word,
        input  fill_last,
        input  wb_done,
        input  wb_word
    );

    modport ctrl (
        input  miss,
        input  victim_dirty,
        input  victim_tag,
        output fill_word,
        output fill_last,
        output wb_done,
        output wb_word
    );

endinterface

// ==== logic/dcache_pkg.sv ====
//----------------------------------------------------------------------
// Types shared by the cache arrays, the miss controller and the
// testbench. Address words are decoded through the union so that every
// block agrees on where tag, index and offsets sit.
//----------------------------------------------------------------------
`include "dcache_defs.svh"

package dcache_pkg;

    typedef logic [`DC_WORD_W-1:0] word_t;

    typedef struct packed {
        logic [`DC_TAG_W-1:0] tag;
        logic [`DC_IDX_W-1:0] idx;
        logic                 blkoff;  // word within the block
        logic [1:0]           byteoff;
    } addr_fields_t;

    typedef union packed {
        word_t        word;
        addr_fields_t fields;
    } dcache_addr_u;

    // write-back states come first so a dirty miss runs straight through
    typedef enum logic [2:0] {
        IDLE,
        WB0,
        WB1,
        FILL0,
        FILL1
    } miss_state_e;

endpackage

// ==== logic/dcache_defs.svh ====
//----------------------------------------------------------------------
// Geometry of the data cache: two ways of eight sets, two words per
// block, 32-bit words and byte addresses. Included by the package and
// by every RTL file that sizes its storage from these values.
//----------------------------------------------------------------------
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// data and address width
`define DC_WORD_W 32

`define DC_SETS 8
`define DC_IDX_W 3

// what is left of the address above index, word and byte offset
`define DC_TAG_W 26

`define DC_BLK_WORDS 2

`endif
